// File: prog_input.txt
// hex words, each @ line sets the word offset of a section
// @00 counts: program words, data words, data SRAM accesses, trace records
@00
00000020 00000002 00000003 0000001c
// initial data memory from data address 0
@08
13579bdf 2468ace0
// data SRAM accesses: address  write data  strobes
@10
00000008 80001234 0000000f
00000008 00000000 00000000
00000004 00000000 00000000
// trace records: pc  register  value
@20
00000000 01 00001234
00000004 02 fffffff8
00000008 03 80000000
0000000c 04 0000f0f0
00000010 05 0000122c
00000014 06 0000123c
00000018 07 00000000
0000001c 08 0000debc
00000020 09 0000f0f0
00000024 0a 80001234
00000028 0b ffff0f08
0000002c 0c ffff0d0b
00000030 0d 00000001
00000034 0e 00000000
00000038 0f 00012340
0000003c 10 00800000
00000040 11 ff800000
00000044 12 12340000
00000048 13 0000ffff
0000004c 14 ffff8000
00000050 15 00000001
00000054 16 00000001
00000058 17 00008000
0000005c 18 ffffff07
00000064 19 80001234
00000068 1a 2468ace0
0000006c 00 00000055
0000007c 1b 00000007
// program from pc 0
@80
// addiu addi lui ori
24011234 2002fff8 3c038000 3404f0f0
// addu subu add sub
00222821 00223023 00633820 00814022
// and or xor nor
00444824 00235025 00445826 00246027
// slt sltu sll srl
0061682a 0061702b 00017900 00038202
// sra sllv srlv srav
00038a03 00819004 00829806 0083a007
// slti sltiu andi xori
2855ffff 2c36ffff 30578001 385800ff
// sw lw lw addiu to r0
ac0a0008 8c190008 8c1a0004 24000055
// nop nop nop addiu reading r0
00000000 00000000 00000000 241b0007

// File: vlog.f
cpu_isa_pkg.sv
cpu_pipe_pkg.sv
fetch_stage.sv
decode_stage.sv
reg_file.sv
execute_stage.sv
mem_wb_stage.sv
cpu_top.sv
tb_sram_model.sv
tb_cpu.sv

// File: tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu
	import cpu_isa_pkg::*;
();

	localparam int TIMEOUT     = 500;
	localparam int MEM_DEPTH   = 1024;
	localparam int IMAGE_WORDS = 256;
	localparam int DATA_BASE   = 'h08;
	localparam int ACC_BASE    = 'h10;
	localparam int REC_BASE    = 'h20;
	localparam int PROG_BASE   = 'h80;

	logic       clk;
	logic       rst;
	logic       inst_sram_en;
	word_t      inst_sram_addr;
	word_t      inst_sram_rdata;
	logic       data_sram_en;
	logic [3:0] data_sram_wen;
	word_t      data_sram_addr;
	word_t      data_sram_wdata;
	word_t      data_sram_rdata;
	word_t      debug_wb_pc;
	logic [3:0] debug_wb_rf_wen;
	reg_addr_t  debug_wb_rf_wnum;
	word_t      debug_wb_rf_wdata;

	word_t image [0:IMAGE_WORDS-1];
	int    n_prog;
	int    n_data;
	int    n_acc;
	int    n_rec;
	int    pass_count;
	int    fail_count;
	int    acc_seen;
	int    fetch_edges;
	int    fetch_seen;
	int    fetch_errs;
	int    k;
	logic  lost;

	cpu_top #(
		.RESET_PC (32'h0)
	) uut (
		.clk               (clk),
		.rst               (rst),
		.inst_sram_en      (inst_sram_en),
		.inst_sram_addr    (inst_sram_addr),
		.inst_sram_rdata   (inst_sram_rdata),
		.data_sram_en      (data_sram_en),
		.data_sram_wen     (data_sram_wen),
		.data_sram_addr    (data_sram_addr),
		.data_sram_wdata   (data_sram_wdata),
		.data_sram_rdata   (data_sram_rdata),
		.debug_wb_pc       (debug_wb_pc),
		.debug_wb_rf_wen   (debug_wb_rf_wen),
		.debug_wb_rf_wnum  (debug_wb_rf_wnum),
		.debug_wb_rf_wdata (debug_wb_rf_wdata)
	);

	tb_sram_model #(
		.DEPTH (MEM_DEPTH)
	) srams (
		.clk        (clk),
		.inst_en    (inst_sram_en),
		.inst_addr  (inst_sram_addr),
		.inst_rdata (inst_sram_rdata),
		.data_en    (data_sram_en),
		.data_wen   (data_sram_wen),
		.data_addr  (data_sram_addr),
		.data_wdata (data_sram_wdata),
		.data_rdata (data_sram_rdata)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	////////////////////////////////////////
	// memory setup

	task automatic load_memories();
		int i;
		for (i = 0; i < MEM_DEPTH; i++)
		begin
			if (i < n_prog)
				srams.imem[i] = image[PROG_BASE + i];
			else
				srams.imem[i] = '0;
			// untouched data words carry their own byte address
			if (i < n_data)
				srams.dmem[i] = image[DATA_BASE + i];
			else
				srams.dmem[i] = 32'hd0d0_0000 | word_t'(i * 4);
		end
	endtask

	////////////////////////////////////////
	// trace checks

	task automatic wait_trace(output logic found);
		int waited;
		waited = 0;
		found  = 1'b0;
		while (!found && waited < TIMEOUT)
		begin
			@(posedge clk);
			if (debug_wb_rf_wen != 4'h0)
				found = 1'b1;
			else
				waited++;
		end
	endtask

	task automatic check_record(input int idx);
		word_t exp_pc;
		word_t exp_num;
		word_t exp_val;
		logic  found;
		int    errs;
		exp_pc  = image[REC_BASE + 3 * idx];
		exp_num = image[REC_BASE + 3 * idx + 1];
		exp_val = image[REC_BASE + 3 * idx + 2];
		errs    = 0;
		wait_trace(found);
		if (!found)
		begin
			$display("record %0d: no write-back trace within %0d cycles", idx, TIMEOUT);
			fail_count++;
			lost = 1'b1;
		end
		else
		begin
			if (debug_wb_pc !== exp_pc)
			begin
				$display("CHECK FAILED debug_wb_pc: expected %h, got %h", exp_pc, debug_wb_pc);
				errs++;
			end
			if (debug_wb_rf_wen !== 4'hf)
			begin
				$display("CHECK FAILED debug_wb_rf_wen: expected f, got %h", debug_wb_rf_wen);
				errs++;
			end
			if (debug_wb_rf_wnum !== exp_num[4:0])
			begin
				$display("CHECK FAILED debug_wb_rf_wnum: expected %h, got %h",
					exp_num[4:0], debug_wb_rf_wnum);
				errs++;
			end
			if (debug_wb_rf_wdata !== exp_val)
			begin
				$display("CHECK FAILED debug_wb_rf_wdata: expected %h, got %h",
					exp_val, debug_wb_rf_wdata);
				errs++;
			end
			if (errs == 0)
				pass_count++;
			else
				fail_count++;
			$display("record %0d pc %h reg %0d: %s", idx, exp_pc, exp_num,
				(errs == 0) ? "ok" : "wrong");
		end
	endtask

	// nothing more may retire once the expected records are used up
	task automatic check_trace_ends();
		int extra;
		int c;
		extra = 0;
		for (c = 0; c < TIMEOUT; c++)
		begin
			@(posedge clk);
			if (debug_wb_rf_wen != 4'h0)
			begin
				$display("unexpected write-back trace at pc %h", debug_wb_pc);
				extra++;
			end
		end
		if (acc_seen != n_acc)
			$display("data SRAM saw %0d accesses, expected %0d", acc_seen, n_acc);
		if (extra == 0 && acc_seen == n_acc)
			pass_count++;
		else
			fail_count++;
		$display("end of trace: %0d extra records, %0d data accesses: %s", extra, acc_seen,
			(extra == 0 && acc_seen == n_acc) ? "ok" : "wrong");
	endtask

	////////////////////////////////////////
	// data SRAM pins

	task automatic check_data_access();
		word_t exp_addr;
		word_t exp_data;
		word_t exp_wen;
		int    errs;
		errs = 0;
		if (acc_seen >= n_acc)
		begin
			$display("data SRAM access at address %h was not expected", data_sram_addr);
			fail_count++;
		end
		else
		begin
			exp_addr = image[ACC_BASE + 3 * acc_seen];
			exp_data = image[ACC_BASE + 3 * acc_seen + 1];
			exp_wen  = image[ACC_BASE + 3 * acc_seen + 2];
			if (data_sram_addr !== exp_addr)
			begin
				$display("CHECK FAILED data_sram_addr: expected %h, got %h",
					exp_addr, data_sram_addr);
				errs++;
			end
			if (data_sram_wen !== exp_wen[3:0])
			begin
				$display("CHECK FAILED data_sram_wen: expected %h, got %h",
					exp_wen[3:0], data_sram_wen);
				errs++;
			end
			if (exp_wen != '0 && data_sram_wdata !== exp_data)
			begin
				$display("CHECK FAILED data_sram_wdata: expected %h, got %h",
					exp_data, data_sram_wdata);
				errs++;
			end
			if (errs == 0)
				pass_count++;
			else
				fail_count++;
			$display("data access %0d at %h: %s", acc_seen, exp_addr,
				(errs == 0) ? "ok" : "wrong");
		end
		acc_seen++;
	endtask

	always @(posedge clk)
	begin
		if (!rst && data_sram_en)
			check_data_access();
	end

	////////////////////////////////////////
	// instruction SRAM pins

	// one idle cycle after release, then one request per cycle from pc 0
	always @(posedge clk)
	begin
		if (!rst)
		begin
			if (fetch_edges == 0)
			begin
				if (inst_sram_en !== 1'b0)
				begin
					$display("CHECK FAILED inst_sram_en: expected 0, got %h", inst_sram_en);
					fetch_errs++;
				end
			end
			else if (inst_sram_en !== 1'b1)
			begin
				$display("CHECK FAILED inst_sram_en: expected 1, got %h", inst_sram_en);
				fetch_errs++;
			end
			else
			begin
				if (inst_sram_addr !== word_t'(fetch_seen * 4))
				begin
					$display("CHECK FAILED inst_sram_addr: expected %h, got %h",
						word_t'(fetch_seen * 4), inst_sram_addr);
					fetch_errs++;
				end
				fetch_seen++;
			end
			fetch_edges++;
		end
	end

	task automatic report_fetch();
		if (fetch_errs == 0)
			pass_count++;
		else
			fail_count++;
		$display("instruction fetch: %0d requests: %s", fetch_seen,
			(fetch_errs == 0) ? "ok" : "wrong");
	endtask

	////////////////////////////////////////
	// main sequence

	initial
	begin
		rst         = 1'b1;
		pass_count  = 0;
		fail_count  = 0;
		acc_seen    = 0;
		fetch_edges = 0;
		fetch_seen  = 0;
		fetch_errs  = 0;
		lost        = 1'b0;
		$readmemh("prog_input.txt", image);
		n_prog = int'(image[0]);
		n_data = int'(image[1]);
		n_acc  = int'(image[2]);
		n_rec  = int'(image[3]);
		load_memories();

		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		for (k = 0; k < n_rec && !lost; k++)
			check_record(k);
		if (!lost)
			check_trace_ends();
		report_fetch();

		$display("%0d tests passed, %0d tests failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: tb_sram_model.sv
`timescale 1ns/1ps

module tb_sram_model
	import cpu_isa_pkg::*;
#(
	parameter int DEPTH = 1024
)
(
	input  logic       clk,
	input  logic       inst_en,
	input  word_t      inst_addr,
	output word_t      inst_rdata,
	input  logic       data_en,
	input  logic [3:0] data_wen,
	input  word_t      data_addr,
	input  word_t      data_wdata,
	output word_t      data_rdata
);

	localparam int IDX_W = $clog2(DEPTH);

	word_t imem [0:DEPTH-1];
	word_t dmem [0:DEPTH-1];

	logic  inst_rd;
	word_t inst_rd_addr;
	logic  data_rd;
	word_t data_rd_addr;

	function automatic logic in_range(input word_t addr);
		return addr[31:2] < DEPTH;
	endfunction

	initial
	begin
		inst_rd    = 1'b0;
		data_rd    = 1'b0;
		inst_rdata = '0;
		data_rdata = '0;
	end

	// requests and writes taken on the rising edge
	always @(posedge clk)
	begin
		inst_rd      <= inst_en;
		inst_rd_addr <= inst_addr;
		data_rd      <= data_en && (data_wen == 4'h0);
		data_rd_addr <= data_addr;
		if (data_en && data_wen != 4'h0 && in_range(data_addr))
			dmem[data_addr[IDX_W+1:2]] <= data_wdata;
	end

	// read data one cycle later, out of range reads as zero
	always @(negedge clk)
	begin
		if (inst_rd && in_range(inst_rd_addr))
			inst_rdata <= imem[inst_rd_addr[IDX_W+1:2]];
		else
			inst_rdata <= '0;
		if (data_rd && in_range(data_rd_addr))
			data_rdata <= dmem[data_rd_addr[IDX_W+1:2]];
		else
			data_rdata <= '0;
	end

endmodule

// File: cpu_top.sv
`timescale 1ns/1ps

module cpu_top
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;
#(
	parameter word_t RESET_PC = 32'hbfc00000
)
(
	input  logic       clk,
	input  logic       rst,

	output logic       inst_sram_en,
	output word_t      inst_sram_addr,
	input  word_t      inst_sram_rdata,

	output logic       data_sram_en,
	output logic [3:0] data_sram_wen,
	output word_t      data_sram_addr,
	output word_t      data_sram_wdata,
	input  word_t      data_sram_rdata,

	output word_t      debug_wb_pc,
	output logic [3:0] debug_wb_rf_wen,
	output reg_addr_t  debug_wb_rf_wnum,
	output word_t      debug_wb_rf_wdata
);

	logic      if_valid;
	word_t     if_pc;
	reg_addr_t rf_raddr1;
	reg_addr_t rf_raddr2;
	word_t     rf_rdata1;
	word_t     rf_rdata2;
	logic      de_valid;
	de_bus_t   de_bus;
	logic      ex_valid;
	em_bus_t   em_bus;
	logic      rf_wen;
	reg_addr_t rf_waddr;
	word_t     rf_wdata;

	fetch_stage #(
		.RESET_PC (RESET_PC)
	) u_fetch (
		.clk            (clk),
		.rst            (rst),
		.inst_sram_en   (inst_sram_en),
		.inst_sram_addr (inst_sram_addr),
		.if_valid       (if_valid),
		.if_pc          (if_pc)
	);

	// instruction word goes straight from the SRAM into decode
	decode_stage u_decode (
		.clk       (clk),
		.rst       (rst),
		.if_valid  (if_valid),
		.if_pc     (if_pc),
		.inst      (inst_sram_rdata),
		.rf_raddr1 (rf_raddr1),
		.rf_raddr2 (rf_raddr2),
		.rf_rdata1 (rf_rdata1),
		.rf_rdata2 (rf_rdata2),
		.de_valid  (de_valid),
		.de_bus    (de_bus)
	);

	reg_file u_reg_file (
		.clk    (clk),
		.rst    (rst),
		.raddr1 (rf_raddr1),
		.raddr2 (rf_raddr2),
		.rdata1 (rf_rdata1),
		.rdata2 (rf_rdata2),
		.wen    (rf_wen),
		.waddr  (rf_waddr),
		.wdata  (rf_wdata)
	);

	execute_stage u_execute (
		.clk      (clk),
		.rst      (rst),
		.de_valid (de_valid),
		.de_bus   (de_bus),
		.ex_valid (ex_valid),
		.em_bus   (em_bus)
	);

	mem_wb_stage u_mem_wb (
		.clk             (clk),
		.rst             (rst),
		.ex_valid        (ex_valid),
		.em_bus          (em_bus),
		.data_sram_en    (data_sram_en),
		.data_sram_wen   (data_sram_wen),
		.data_sram_addr  (data_sram_addr),
		.data_sram_wdata (data_sram_wdata),
		.data_sram_rdata (data_sram_rdata),
		.rf_wen          (rf_wen),
		.rf_waddr        (rf_waddr),
		.rf_wdata        (rf_wdata),
		.debug_wb_pc     (debug_wb_pc),
		.debug_wb_rf_wen (debug_wb_rf_wen)
	);

	// trace shares the register file write port
	assign debug_wb_rf_wnum  = rf_waddr;
	assign debug_wb_rf_wdata = rf_wdata;

endmodule

// File: mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       ex_valid,
	input  em_bus_t    em_bus,
	output logic       data_sram_en,
	output logic [3:0] data_sram_wen,
	output word_t      data_sram_addr,
	output word_t      data_sram_wdata,
	input  word_t      data_sram_rdata,
	output logic       rf_wen,
	output reg_addr_t  rf_waddr,
	output word_t      rf_wdata,
	output word_t      debug_wb_pc,
	output logic [3:0] debug_wb_rf_wen
);

	logic    mw_valid;
	mw_bus_t mw_bus;

	////////////////////////////////////////
	// memory access, word only
	assign data_sram_en    = ex_valid && (em_bus.load || em_bus.store);
	assign data_sram_wen   = {4{ex_valid && em_bus.store}};
	assign data_sram_addr  = em_bus.alu_res;
	assign data_sram_wdata = em_bus.st_data;

	always_ff @(posedge clk)
	begin
		if (rst)
			mw_valid <= 1'b0;
		else
			mw_valid <= ex_valid;
	end

	always_ff @(posedge clk)
	begin
		mw_bus.pc      <= em_bus.pc;
		mw_bus.alu_res <= em_bus.alu_res;
		mw_bus.dest    <= em_bus.dest;
		mw_bus.rf_we   <= em_bus.rf_we;
		mw_bus.load    <= em_bus.load;
	end

	////////////////////////////////////////
	// write back, load data arrives this cycle
	assign rf_wen   = mw_valid && mw_bus.rf_we;
	assign rf_waddr = mw_bus.dest;
	assign rf_wdata = mw_bus.load ? data_sram_rdata : mw_bus.alu_res;

	assign debug_wb_pc     = mw_bus.pc;
	assign debug_wb_rf_wen = {4{rf_wen}};

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps

module execute_stage
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    de_valid,
	input  de_bus_t de_bus,
	output logic    ex_valid,
	output em_bus_t em_bus
);

	word_t  a;
	word_t  b;
	shamt_t sh;
	word_t  result;

	assign a  = (de_bus.a_sel == A_SEL_SA) ? word_t'(de_bus.shamt) : de_bus.rs_val;
	assign b  = (de_bus.b_sel == B_SEL_IMM) ? de_bus.imm : de_bus.rt_val;
	assign sh = a[SHAMT_W-1:0];

	////////////////////////////////////////
	// alu, one-hot select
	always_comb
	begin
		result = '0;
		if (de_bus.alu_op[ALU_ADD])
			result |= a + b;
		if (de_bus.alu_op[ALU_SUB])
			result |= a - b;
		if (de_bus.alu_op[ALU_SLT])
			result |= word_t'($signed(a) < $signed(b));
		if (de_bus.alu_op[ALU_SLTU])
			result |= word_t'(a < b);
		if (de_bus.alu_op[ALU_AND])
			result |= a & b;
		if (de_bus.alu_op[ALU_NOR])
			result |= ~(a | b);
		if (de_bus.alu_op[ALU_OR])
			result |= a | b;
		if (de_bus.alu_op[ALU_XOR])
			result |= a ^ b;
		if (de_bus.alu_op[ALU_SLL])
			result |= b << sh;
		if (de_bus.alu_op[ALU_SRL])
			result |= b >> sh;
		if (de_bus.alu_op[ALU_SRA])
			result |= word_t'($signed(b) >>> sh);
		if (de_bus.alu_op[ALU_LUI])
			result |= {b[IMM_W-1:0], {(WORD_W-IMM_W){1'b0}}};
	end

	////////////////////////////////////////
	// execute/memory register
	always_ff @(posedge clk)
	begin
		if (rst)
			ex_valid <= 1'b0;
		else
			ex_valid <= de_valid;
	end

	always_ff @(posedge clk)
	begin
		em_bus.pc      <= de_bus.pc;
		em_bus.alu_res <= result;
		em_bus.st_data <= de_bus.rt_val;
		em_bus.dest    <= de_bus.dest;
		em_bus.rf_we   <= de_bus.rf_we;
		em_bus.load    <= de_bus.load;
		em_bus.store   <= de_bus.store;
	end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file
	import cpu_isa_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  reg_addr_t raddr1,
	input  reg_addr_t raddr2,
	output word_t     rdata1,
	output word_t     rdata2,
	input  logic      wen,
	input  reg_addr_t waddr,
	input  word_t     wdata
);

	// register zero has no storage
	word_t regs [1:31];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wen && waddr != '0)
			regs[waddr] <= wdata;
	end

	// same-cycle write seen by the read
	function automatic word_t read_port(input reg_addr_t addr);
		if (addr == '0)
			return '0;
		else if (wen && addr == waddr)
			return wdata;
		else
			return regs[addr];
	endfunction

	always_comb
	begin
		rdata1 = read_port(raddr1);
		rdata2 = read_port(raddr2);
	end

endmodule

// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      if_valid,
	input  word_t     if_pc,
	input  word_t     inst,
	output reg_addr_t rf_raddr1,
	output reg_addr_t rf_raddr2,
	input  word_t     rf_rdata1,
	input  word_t     rf_rdata2,
	output logic      de_valid,
	output de_bus_t   de_bus
);

	opcode_t          op;
	funct_t           fn;
	reg_addr_t        rs;
	reg_addr_t        rt;
	reg_addr_t        rd;
	shamt_t           sa;
	logic [IMM_W-1:0] imm16;
	logic             zero_ext;
	logic             use_rd;
	de_bus_t          de_next;

	////////////////////////////////////////
	// fields
	assign op    = inst[31:26];
	assign rs    = inst[25:21];
	assign rt    = inst[20:16];
	assign rd    = inst[15:11];
	assign sa    = inst[10:6];
	assign fn    = inst[5:0];
	assign imm16 = inst[IMM_W-1:0];

	assign rf_raddr1 = rs;
	assign rf_raddr2 = rt;

	// logical immediates are zero extended
	assign zero_ext = (op == OP_ANDI) || (op == OP_ORI) || (op == OP_XORI);

	////////////////////////////////////////
	// control
	always_comb
	begin
		de_next        = '0;
		use_rd         = 1'b0;
		de_next.a_sel  = A_SEL_RS;
		de_next.b_sel  = B_SEL_RT;
		de_next.pc     = if_pc;
		de_next.shamt  = sa;
		de_next.rs_val = rf_rdata1;
		de_next.rt_val = rf_rdata2;
		de_next.imm    = zero_ext ? {{(WORD_W-IMM_W){1'b0}}, imm16}
		                          : {{(WORD_W-IMM_W){imm16[IMM_W-1]}}, imm16};
		case (op)
			OP_SPECIAL:
			begin
				use_rd        = 1'b1;
				de_next.rf_we = 1'b1;
				case (fn)
					FN_ADD, FN_ADDU: de_next.alu_op[ALU_ADD]  = 1'b1;
					FN_SUB, FN_SUBU: de_next.alu_op[ALU_SUB]  = 1'b1;
					FN_SLT:          de_next.alu_op[ALU_SLT]  = 1'b1;
					FN_SLTU:         de_next.alu_op[ALU_SLTU] = 1'b1;
					FN_AND:          de_next.alu_op[ALU_AND]  = 1'b1;
					FN_OR:           de_next.alu_op[ALU_OR]   = 1'b1;
					FN_XOR:          de_next.alu_op[ALU_XOR]  = 1'b1;
					FN_NOR:          de_next.alu_op[ALU_NOR]  = 1'b1;
					FN_SLLV:         de_next.alu_op[ALU_SLL]  = 1'b1;
					FN_SRLV:         de_next.alu_op[ALU_SRL]  = 1'b1;
					FN_SRAV:         de_next.alu_op[ALU_SRA]  = 1'b1;
					FN_SLL:
					begin
						de_next.alu_op[ALU_SLL] = 1'b1;
						de_next.a_sel           = A_SEL_SA;
					end
					FN_SRL:
					begin
						de_next.alu_op[ALU_SRL] = 1'b1;
						de_next.a_sel           = A_SEL_SA;
					end
					FN_SRA:
					begin
						de_next.alu_op[ALU_SRA] = 1'b1;
						de_next.a_sel           = A_SEL_SA;
					end
					default:         de_next.rf_we = 1'b0;
				endcase
			end
			OP_ADDI, OP_ADDIU: de_next.alu_op[ALU_ADD]  = 1'b1;
			OP_SLTI:           de_next.alu_op[ALU_SLT]  = 1'b1;
			OP_SLTIU:          de_next.alu_op[ALU_SLTU] = 1'b1;
			OP_ANDI:           de_next.alu_op[ALU_AND]  = 1'b1;
			OP_ORI:            de_next.alu_op[ALU_OR]   = 1'b1;
			OP_XORI:           de_next.alu_op[ALU_XOR]  = 1'b1;
			OP_LUI:            de_next.alu_op[ALU_LUI]  = 1'b1;
			OP_LW:
			begin
				de_next.alu_op[ALU_ADD] = 1'b1;
				de_next.load            = 1'b1;
			end
			OP_SW:
			begin
				de_next.alu_op[ALU_ADD] = 1'b1;
				de_next.store           = 1'b1;
			end
			default: ;
		endcase

		// immediate forms take b from imm16 and write rt unless storing
		if (op != OP_SPECIAL && de_next.alu_op != '0)
		begin
			de_next.b_sel = B_SEL_IMM;
			de_next.rf_we = !de_next.store;
		end

		// zero word is the nop
		if (inst == '0)
			de_next.rf_we = 1'b0;

		de_next.dest = use_rd ? rd : rt;
	end

	////////////////////////////////////////
	// decode/execute register
	always_ff @(posedge clk)
	begin
		if (rst)
			de_valid <= 1'b0;
		else
			de_valid <= if_valid;
	end

	always_ff @(posedge clk)
	begin
		de_bus <= de_next;
	end

endmodule

// File: fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
	import cpu_isa_pkg::*;
#(
	parameter word_t RESET_PC = 32'hbfc00000
)
(
	input  logic  clk,
	input  logic  rst,
	output logic  inst_sram_en,
	output word_t inst_sram_addr,
	output logic  if_valid,
	output word_t if_pc
);

	word_t pc;
	logic  fetch_on;

	// one idle cycle after reset before the first request
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			fetch_on <= 1'b0;
			pc       <= RESET_PC;
			if_valid <= 1'b0;
		end
		else
		begin
			fetch_on <= 1'b1;
			if_valid <= fetch_on;
			if (fetch_on)
				pc <= pc + 32'd4;
		end
	end

	// pc of the word coming back from the SRAM
	always_ff @(posedge clk)
	begin
		if_pc <= pc;
	end

	assign inst_sram_en   = fetch_on;
	assign inst_sram_addr = pc;

endmodule

// File: cpu_pipe_pkg.sv
package cpu_pipe_pkg;

	import cpu_isa_pkg::*;

	// one-hot ALU operation, one bit per function
	localparam int ALU_OPS = 12;

	typedef logic [ALU_OPS-1:0] alu_op_t;

	localparam int ALU_ADD  = 0;
	localparam int ALU_SUB  = 1;
	localparam int ALU_SLT  = 2;
	localparam int ALU_SLTU = 3;
	localparam int ALU_AND  = 4;
	localparam int ALU_NOR  = 5;
	localparam int ALU_OR   = 6;
	localparam int ALU_XOR  = 7;
	localparam int ALU_SLL  = 8;
	localparam int ALU_SRL  = 9;
	localparam int ALU_SRA  = 10;
	localparam int ALU_LUI  = 11;

	// operand selects
	typedef logic a_sel_t;
	typedef logic b_sel_t;

	localparam a_sel_t A_SEL_RS  = 1'b0;
	localparam a_sel_t A_SEL_SA  = 1'b1;
	localparam b_sel_t B_SEL_RT  = 1'b0;
	localparam b_sel_t B_SEL_IMM = 1'b1;

	////////////////////////////////////////
	// stage buses
	typedef struct packed {
		word_t     pc;
		alu_op_t   alu_op;
		a_sel_t    a_sel;
		b_sel_t    b_sel;
		shamt_t    shamt;
		word_t     rs_val;
		word_t     rt_val;
		word_t     imm;
		reg_addr_t dest;
		logic      rf_we;
		logic      load;
		logic      store;
	} de_bus_t;

	typedef struct packed {
		word_t     pc;
		word_t     alu_res;
		word_t     st_data;
		reg_addr_t dest;
		logic      rf_we;
		logic      load;
		logic      store;
	} em_bus_t;

	typedef struct packed {
		word_t     pc;
		word_t     alu_res;
		reg_addr_t dest;
		logic      rf_we;
		logic      load;
	} mw_bus_t;

endpackage

// File: cpu_isa_pkg.sv
package cpu_isa_pkg;

	// instruction field widths
	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int OPCODE_W   = 6;
	localparam int FUNCT_W    = 6;
	localparam int SHAMT_W    = 5;
	localparam int IMM_W      = 16;

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [OPCODE_W-1:0]   opcode_t;
	typedef logic [FUNCT_W-1:0]    funct_t;
	typedef logic [SHAMT_W-1:0]    shamt_t;

	////////////////////////////////////////
	// opcodes
	localparam opcode_t OP_SPECIAL = 6'b000000;
	localparam opcode_t OP_ADDI    = 6'b001000;
	localparam opcode_t OP_ADDIU   = 6'b001001;
	localparam opcode_t OP_SLTI    = 6'b001010;
	localparam opcode_t OP_SLTIU   = 6'b001011;
	localparam opcode_t OP_ANDI    = 6'b001100;
	localparam opcode_t OP_ORI     = 6'b001101;
	localparam opcode_t OP_XORI    = 6'b001110;
	localparam opcode_t OP_LUI     = 6'b001111;
	localparam opcode_t OP_LW      = 6'b100011;
	localparam opcode_t OP_SW      = 6'b101011;

	////////////////////////////////////////
	// funct codes under OP_SPECIAL
	localparam funct_t FN_SLL  = 6'b000000;
	localparam funct_t FN_SRL  = 6'b000010;
	localparam funct_t FN_SRA  = 6'b000011;
	localparam funct_t FN_SLLV = 6'b000100;
	localparam funct_t FN_SRLV = 6'b000110;
	localparam funct_t FN_SRAV = 6'b000111;
	localparam funct_t FN_ADD  = 6'b100000;
	localparam funct_t FN_ADDU = 6'b100001;
	localparam funct_t FN_SUB  = 6'b100010;
	localparam funct_t FN_SUBU = 6'b100011;
	localparam funct_t FN_AND  = 6'b100100;
	localparam funct_t FN_OR   = 6'b100101;
	localparam funct_t FN_XOR  = 6'b100110;
	localparam funct_t FN_NOR  = 6'b100111;
	localparam funct_t FN_SLT  = 6'b101010;
	localparam funct_t FN_SLTU = 6'b101011;

endpackage
